/* bench/conv_checker.sv */
`timescale 1ns/1ns

module conv_checker #(
	parameter int IMG_W = 8
) (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  cfg_valid,
	input  conv_pkg::codebook_t   cfg_codebook,
	input  conv_pkg::index_word_t cfg_index,
	input  conv_pkg::acc_t        cfg_bias,
	input  logic                  in_valid,
	input  logic                  in_ready,
	input  conv_pkg::pixel_t      in_pixel,
	input  logic                  out_valid,
	input  logic                  out_ready,
	input  conv_pkg::out_pixel_t  out_pixel,
	output int                    errors,
	output int                    results
);

	// whole frame kept by row and column
	logic signed [7:0]  frame [IMG_W][IMG_W];
	logic [31:0]        codebook;
	logic [17:0]        index;
	logic signed [15:0] bias;
	int                 col;
	int                 row;
	logic               rstn_q = 1'b0;
	logic [7:0]         want;
	logic [7:0]         expected [$];

	function automatic logic [7:0] requantize(input logic [15:0] s);
		if (s[15])
			return 8'd0;
		if (s[14:12] != 3'b000)
			return 8'd127;
		return s[12:5];
	endfunction

	// window ending at (r, c) with tap 0 top-left
	function automatic logic [7:0] window_result(input int r, input int c);
		int                acc;
		int                t;
		logic signed [7:0] w;
		acc = int'(bias);
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				t = 3 * i + j;
				w = codebook[8 * index[2 * t +: 2] +: 8];
				acc += int'(frame[r - 2 + i][c - 2 + j]) * int'(w);
			end
		end
		// low 16 bits give the wrapped sum
		return requantize(acc[15:0]);
	endfunction

	always @(posedge clk) begin
		rstn_q <= rstn;
		if (!rstn) begin
			col = 0;
			row = 0;
			expected.delete();
		end else begin
			// first edge out of reset
			if (!rstn_q) begin
				if (out_valid !== 1'b0) begin
					$display("[ERROR] %0t ns out_valid expected 0 actual %b", $time, out_valid);
					errors++;
				end
				if (in_ready !== 1'b1) begin
					$display("[ERROR] %0t ns in_ready expected 1 actual %b", $time, in_ready);
					errors++;
				end
			end
			if (cfg_valid) begin
				codebook = cfg_codebook;
				index    = cfg_index;
				bias     = cfg_bias;
			end
			if (in_valid && in_ready) begin
				frame[row][col] = in_pixel;
				if (row >= 2 && col >= 2)
					expected.push_back(window_result(row, col));
				if (col == IMG_W - 1) begin
					col = 0;
					row = (row == IMG_W - 1) ? 0 : row + 1;
				end else begin
					col = col + 1;
				end
			end
			if (out_valid && out_ready) begin
				results++;
				if (expected.size() == 0) begin
					$display("%0t ns: the DUT delivered a result with no window behind it",
						$time);
					errors++;
				end else begin
					want = expected.pop_front();
					if (out_pixel !== want) begin
						$display("[ERROR] %0t ns out_pixel expected %0d actual %0d",
							$time, want, out_pixel);
						errors++;
					end
				end
			end
		end
	end

endmodule

/* bench/tb_top.sv */
`timescale 1ns/1ns

module tb_top;

	localparam int IMG_W = 8;
	localparam int PIXELS = IMG_W * IMG_W;
	localparam int PER_FRAME = (IMG_W - 2) * (IMG_W - 2);
	// five frames, up to four cycles per pixel when stalled, plus margin
	localparam int MAX_CYCLES = 5 * PIXELS * 4 + 920;

	logic                  clk = 1'b0;
	logic                  rstn;
	logic                  cfg_valid;
	conv_pkg::codebook_t   cfg_codebook;
	conv_pkg::index_word_t cfg_index;
	conv_pkg::acc_t        cfg_bias;
	logic                  in_valid;
	logic                  in_ready;
	conv_pkg::pixel_t      in_pixel;
	logic                  out_valid;
	logic                  out_ready = 1'b1;
	conv_pkg::out_pixel_t  out_pixel;

	logic in_xfer = 1'b0;
	int   stall_pct = 0;
	int   cycles = 0;
	int   errors;
	int   results;
	int   tests_run = 0;
	int   tests_failed = 0;

	always #50 clk = ~clk;

	conv3x3_top #(
		.IMG_W (IMG_W)
	) u_dut (
		.clk          (clk),
		.rstn         (rstn),
		.cfg_valid    (cfg_valid),
		.cfg_codebook (cfg_codebook),
		.cfg_index    (cfg_index),
		.cfg_bias     (cfg_bias),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_pixel     (in_pixel),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_pixel    (out_pixel)
	);

	conv_checker #(
		.IMG_W (IMG_W)
	) u_check (
		.clk          (clk),
		.rstn         (rstn),
		.cfg_valid    (cfg_valid),
		.cfg_codebook (cfg_codebook),
		.cfg_index    (cfg_index),
		.cfg_bias     (cfg_bias),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_pixel     (in_pixel),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_pixel    (out_pixel),
		.errors       (errors),
		.results      (results)
	);

	// pixel taken on the last rising edge
	always @(posedge clk)
		in_xfer <= in_valid && in_ready;

	always @(negedge clk) begin
		if (stall_pct > 0)
			out_ready = int'($urandom % 100) >= stall_pct;
		else
			out_ready = 1'b1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, results went missing (%0d received)",
				cycles, results);
			$display("Something failed");
			$finish;
		end
	end

	task automatic configure(input conv_pkg::codebook_t cb, input conv_pkg::index_word_t idx,
		input conv_pkg::acc_t b);
		@(negedge clk);
		cfg_valid    = 1'b1;
		cfg_codebook = cb;
		cfg_index    = idx;
		cfg_bias     = b;
		@(negedge clk);
		cfg_valid = 1'b0;
	endtask

	task automatic send_frame(input int gap_pct);
		int sent;
		sent = 0;
		while (sent < PIXELS) begin
			@(negedge clk);
			if (in_xfer)
				sent++;
			// valid and data hold until taken
			if (!in_valid || in_xfer) begin
				if (sent < PIXELS && int'($urandom % 100) >= gap_pct) begin
					in_valid = 1'b1;
					in_pixel = conv_pkg::pixel_t'($urandom);
				end else begin
					in_valid = 1'b0;
				end
			end
		end
	endtask

	task automatic run_frame(input int gap_pct);
		int target;
		target = results + PER_FRAME;
		send_frame(gap_pct);
		while (results < target)
			@(negedge clk);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: passed", tests_run, name);
		end
	endtask

	initial begin
		int errs;
		void'($urandom(27207));
		rstn         = 1'b0;
		cfg_valid    = 1'b0;
		cfg_codebook = '0;
		cfg_index    = '0;
		cfg_bias     = '0;
		in_valid     = 1'b0;
		in_pixel     = '0;
		repeat (2) @(negedge clk);

		errs = errors;
		rstn = 1'b1;
		repeat (2) @(negedge clk);
		report_test("idle after reset", errs);

		errs = errors;
		configure($urandom, conv_pkg::index_word_t'($urandom),
			conv_pkg::acc_t'(int'($urandom % 1024) - 512));
		run_frame(0);
		report_test("random frame", errs);

		// weights 1, 16, -16 and 64
		errs = errors;
		configure(32'h40f0_1001, conv_pkg::index_word_t'($urandom), 16'sd0);
		run_frame(0);
		report_test("tap decoding", errs);

		errs = errors;
		configure($urandom, conv_pkg::index_word_t'($urandom),
			conv_pkg::acc_t'(int'($urandom % 1024) - 512));
		stall_pct = 40;
		run_frame(40);
		stall_pct = 0;
		report_test("gaps and stalls", errs);

		errs = errors;
		configure($urandom, conv_pkg::index_word_t'($urandom), 16'sh7000);
		run_frame(0);
		configure($urandom, conv_pkg::index_word_t'($urandom), 16'sh9000);
		run_frame(0);
		report_test("large bias", errs);

		repeat (4) @(negedge clk);
		$display("tests %0d, failed %0d, results %0d, errors %0d",
			tests_run, tests_failed, results, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* project.f */
rtl/conv_pkg.sv
rtl/weight_decoder.sv
rtl/line_window.sv
rtl/mac_requant.sv
rtl/conv3x3_top.sv
bench/conv_checker.sv
bench/tb_top.sv

/* rtl/conv3x3_top.sv */
`timescale 1ns/1ns

module conv3x3_top #(
	parameter int IMG_W = 8
) (
	input  logic                  clk,
	input  logic                  rstn,

	input  logic                  cfg_valid,
	input  conv_pkg::codebook_t   cfg_codebook,
	input  conv_pkg::index_word_t cfg_index,
	input  conv_pkg::acc_t        cfg_bias,

	input  logic                  in_valid,
	output logic                  in_ready,
	input  conv_pkg::pixel_t      in_pixel,

	output logic                  out_valid,
	input  logic                  out_ready,
	output conv_pkg::out_pixel_t  out_pixel
);

	logic               win_valid;
	logic               win_ready;
	conv_pkg::window_t  win_data;
	conv_pkg::weights_t weights;
	conv_pkg::acc_t     bias;

	weight_decoder u_weights (
		.clk          (clk),
		.rstn         (rstn),
		.cfg_valid    (cfg_valid),
		.cfg_codebook (cfg_codebook),
		.cfg_index    (cfg_index),
		.cfg_bias     (cfg_bias),
		.weights      (weights),
		.bias         (bias)
	);

	line_window #(
		.IMG_W (IMG_W)
	) u_window (
		.clk       (clk),
		.rstn      (rstn),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_pixel  (in_pixel),
		.win_valid (win_valid),
		.win_ready (win_ready),
		.win_data  (win_data)
	);

	mac_requant u_mac (
		.clk       (clk),
		.rstn      (rstn),
		.win_valid (win_valid),
		.win_ready (win_ready),
		.win_data  (win_data),
		.weights   (weights),
		.bias      (bias),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_pixel (out_pixel)
	);

endmodule

/* rtl/conv_pkg.sv */
package conv_pkg;

	localparam int KERNEL_TAPS = 9;
	localparam int PIX_W = 8;
	localparam int ACC_W = 16;

	// lowest sum bit that reaches the output
	localparam int REQ_SHIFT = 5;
	// sum bits from here up force saturation
	localparam int SAT_LSB = REQ_SHIFT + 7;
	localparam int OUT_MAX = 127;

	typedef logic signed [PIX_W-1:0] pixel_t;
	typedef logic signed [PIX_W-1:0] weight_t;

	// four weights, entry 0 in the low byte
	typedef logic [4*PIX_W-1:0] codebook_t;

	// nine 2-bit codebook indices, tap 0 in the low bits
	typedef logic [2*KERNEL_TAPS-1:0] index_word_t;

	// tap 0 is top-left, row-major, tap 8 newest
	typedef logic [KERNEL_TAPS*PIX_W-1:0] window_t;
	typedef logic [KERNEL_TAPS*PIX_W-1:0] weights_t;

	// accumulator, also used for the bias
	typedef logic signed [ACC_W-1:0] acc_t;

	typedef logic [7:0] out_pixel_t;

endpackage

/* rtl/line_window.sv */
`timescale 1ns/1ns

module line_window #(
	parameter int IMG_W = 8
) (
	input  logic               clk,
	input  logic               rstn,
	input  logic               in_valid,
	output logic               in_ready,
	input  conv_pkg::pixel_t   in_pixel,
	output logic               win_valid,
	input  logic               win_ready,
	output conv_pkg::window_t  win_data
);

	localparam int PB = $bits(conv_pkg::pixel_t);
	localparam int CW = $clog2(IMG_W);
	localparam logic [CW-1:0] LAST = CW'(IMG_W - 1);

	logic [CW-1:0] col_cnt;
	logic [CW-1:0] row_cnt;
	logic          accept;
	logic          interior;

	// previous row and the row before it, indexed by column
	conv_pkg::pixel_t line_a [IMG_W];
	conv_pkg::pixel_t line_b [IMG_W];
	conv_pkg::pixel_t top_px;
	conv_pkg::pixel_t mid_px;

	// window register empty or being taken
	assign in_ready = !win_valid || win_ready;
	assign accept   = in_valid && in_ready;
	assign interior = (row_cnt >= CW'(2)) && (col_cnt >= CW'(2));

	assign top_px = line_b[col_cnt];
	assign mid_px = line_a[col_cnt];

	// raster position, wraps straight into the next frame
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (accept) begin
			if (col_cnt == LAST) begin
				col_cnt <= '0;
				if (row_cnt == LAST)
					row_cnt <= '0;
				else
					row_cnt <= row_cnt + 1'b1;
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			win_valid <= 1'b0;
		else if (accept)
			win_valid <= interior;
		else if (win_ready)
			win_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			line_b[col_cnt] <= mid_px;
			line_a[col_cnt] <= in_pixel;
			// shift left a column, new right column top to bottom
			win_data <= {in_pixel, win_data[PB*7 +: 2*PB],
				mid_px, win_data[PB*4 +: 2*PB],
				top_px, win_data[PB*1 +: 2*PB]};
		end
	end

	a_col_range: assert property (
		@(posedge clk) disable iff (!rstn)
		col_cnt < IMG_W
	);

	a_win_hold: assert property (
		@(posedge clk) disable iff (!rstn)
		win_valid && !win_ready |=> win_valid && $stable(win_data)
	);

endmodule

/* rtl/mac_requant.sv */
`timescale 1ns/1ns

module mac_requant (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 win_valid,
	output logic                 win_ready,
	input  conv_pkg::window_t    win_data,
	input  conv_pkg::weights_t   weights,
	input  conv_pkg::acc_t       bias,
	output logic                 out_valid,
	input  logic                 out_ready,
	output conv_pkg::out_pixel_t out_pixel
);

	localparam int PB = $bits(conv_pkg::pixel_t);
	localparam int AW = $bits(conv_pkg::acc_t);
	localparam int OW = $bits(conv_pkg::out_pixel_t);

	logic                 s1_valid;
	logic                 s1_adv;
	logic                 s2_adv;
	conv_pkg::acc_t       prod [conv_pkg::KERNEL_TAPS];
	conv_pkg::acc_t       sum;
	conv_pkg::out_pixel_t q_pixel;

	// a stage loads when its register is empty or being taken
	assign s2_adv    = !out_valid || out_ready;
	assign s1_adv    = !s1_valid || s2_adv;
	assign win_ready = s1_adv;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (s1_adv)
				s1_valid <= win_valid;
			if (s2_adv)
				out_valid <= s1_valid;
		end
	end

	// stage 1 holds the nine signed 8x8 products
	always_ff @(posedge clk) begin
		if (s1_adv && win_valid) begin
			for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
				prod[t] <= conv_pkg::acc_t'(conv_pkg::pixel_t'(win_data[PB*t +: PB]))
					* conv_pkg::acc_t'(conv_pkg::weight_t'(weights[PB*t +: PB]));
			end
		end
	end

	// wraps at 16 bits
	always_comb begin
		sum = bias;
		for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
			sum = sum + prod[t];
		end
	end

	always_comb begin
		if (sum[AW-1])
			q_pixel = '0;
		else if (|sum[AW-1:conv_pkg::SAT_LSB])
			q_pixel = OW'(conv_pkg::OUT_MAX);
		else
			q_pixel = sum[conv_pkg::REQ_SHIFT +: OW];
	end

	// stage 2 holds the requantized result
	always_ff @(posedge clk) begin
		if (s2_adv && s1_valid)
			out_pixel <= q_pixel;
	end

	a_out_range: assert property (
		@(posedge clk) disable iff (!rstn)
		out_valid |-> out_pixel <= conv_pkg::OUT_MAX
	);

	a_out_hold: assert property (
		@(posedge clk) disable iff (!rstn)
		out_valid && !out_ready |=> out_valid && $stable(out_pixel)
	);

endmodule

/* rtl/weight_decoder.sv */
`timescale 1ns/1ns

module weight_decoder (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  cfg_valid,
	input  conv_pkg::codebook_t   cfg_codebook,
	input  conv_pkg::index_word_t cfg_index,
	input  conv_pkg::acc_t        cfg_bias,
	output conv_pkg::weights_t    weights,
	output conv_pkg::acc_t        bias
);

	localparam int WB = $bits(conv_pkg::weight_t);

	conv_pkg::codebook_t   codebook_q;
	conv_pkg::index_word_t index_q;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			codebook_q <= '0;
			index_q    <= '0;
			bias       <= '0;
		end else if (cfg_valid) begin
			codebook_q <= cfg_codebook;
			index_q    <= cfg_index;
			bias       <= cfg_bias;
		end
	end

	// every tap picks one codebook byte by its index
	always_comb begin
		for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
			weights[WB*t +: WB] = codebook_q[WB*index_q[2*t +: 2] +: WB];
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_top -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "PASS" && exit 0 \
	|| { echo "FAIL"; exit 1; }
